/* compile.f */
+incdir+hw
hw/lbist_msg_pkg.sv
hw/lbist_cut_pkg.sv
hw/lfsr.sv
hw/lbist_pipe_reg.sv
hw/cut_datapath.sv
hw/misr.sv
hw/lbist_controller.sv
hw/lbist_top.sv
tb/lbist_tb.sv

/* hw/cut_datapath.sv */
// Circuit under test, a 16-bit ALU decoded from each LBIST vector
`default_nettype none
`timescale 1ns/10ps

module cut_datapath (
    // Vector input
    input  logic                     in_val,
    input  lbist_cut_pkg::vector_t   in_msg,
    output logic                     in_rdy,

    // Response output
    output logic                     out_val,
    output lbist_cut_pkg::response_t out_msg,
    input  logic                     out_rdy
);

    import lbist_cut_pkg::*;

    // ======================================================================
    // Operand decode
    // ======================================================================

    logic [HALF_BITS-1:0] a;
    logic [HALF_BITS-1:0] b;
    logic [HALF_BITS-1:0] result;

    assign a = in_msg.a;
    // b field is narrower than a, zero-extend to operand width
    assign b = {{(HALF_BITS - B_BITS){1'b0}}, in_msg.b};

    // ======================================================================
    // ALU
    // ======================================================================

    // Arithmetic wraps at 16 bits
    always_comb begin
        case (in_msg.op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            XOR:     result = a ^ b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // Response packs operand a above the result
    assign out_msg.a      = a;
    assign out_msg.result = result;

    // Purely combinational, handshake passes straight through
    assign out_val = in_val;
    assign in_rdy  = out_rdy;

endmodule

`default_nettype wire

/* hw/lbist_config.svh */
// LBIST configuration macros for datapath widths, feedback taps and count size
`ifndef LBIST_CONFIG_SVH
`define LBIST_CONFIG_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================

// Test vector, CUT response and signature all share one word
`define LBIST_WIDTH 32

// Vector count carried by the start command and the run report
`define LBIST_CNT_BITS 16

// ==========================================================================
// Feedback taps
// ==========================================================================

// Four-tap polynomial for a 32-bit register
// Shared by the LFSR and the MISR
`define LBIST_TAP1 1
`define LBIST_TAP2 5
`define LBIST_TAP3 6
`define LBIST_TAP4 31

`endif

/* hw/lbist_controller.sv */
// LBIST controller that seeds the LFSR, counts absorbed responses and reports
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module lbist_controller (
    input  logic                       clk,
    input  logic                       reset,

    // Run request
    input  logic                       start,
    input  lbist_msg_pkg::start_cmd_t  cmd,

    // LFSR control
    output logic                       seed_val,
    output logic [`LBIST_WIDTH-1:0]    seed_msg,
    input  logic                       seed_rdy,
    output logic                       lfsr_clear,

    // MISR and pipeline control
    output logic                       misr_clear,
    output logic                       misr_arm,
    input  logic                       absorbed,
    input  logic [`LBIST_WIDTH-1:0]    signature,
    output logic                       flush,

    // Run status
    output logic                       busy,
    output logic                       done,
    output lbist_msg_pkg::run_report_t report
);

    import lbist_msg_pkg::*;

    // ======================================================================
    // State, command and counters
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE,
        SEED,
        RUN,
        FINISH
    } ctrl_state_e;

    ctrl_state_e               state;
    ctrl_state_e               next_state;

    start_cmd_t                cmd_q;
    run_report_t               report_q;
    logic [`LBIST_CNT_BITS-1:0] target;
    logic [`LBIST_CNT_BITS-1:0] cnt;
    logic                      last;

    // Zero count runs one vector
    assign target = (cmd_q.count == '0) ? 1'b1 : cmd_q.count;
    // Absorb that brings the count up to the target
    assign last   = absorbed && (cnt == target - 1'b1);

    always_comb begin
        next_state = state;
        case (state)
            // Start while busy never reaches here, so it is ignored
            IDLE:    if (start) next_state = SEED;
            SEED:    if (seed_rdy) next_state = RUN;
            RUN:     if (last) next_state = FINISH;
            FINISH:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Command captured once per run
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cmd_q <= cmd;
        end
    end

    // Response counter, restarted while seeding
    always_ff @(posedge clk) begin
        if (reset || state == SEED) begin
            cnt <= '0;
        end else if (state == RUN && absorbed) begin
            cnt <= cnt + 1'b1;
        end
    end

    // ======================================================================
    // Report
    // ======================================================================

    // MISR is disarmed in FINISH, so its value is final there
    always_ff @(posedge clk) begin
        if (reset) begin
            report_q <= '0;
        end else if (state == FINISH) begin
            report_q <= report;
        end
    end

    // Fresh values already show during the done pulse
    always_comb begin
        report = report_q;
        if (state == FINISH) begin
            report.signature = signature;
            report.count     = target;
        end
    end

    // ======================================================================
    // Control outputs
    // ======================================================================

    assign busy       = (state != IDLE);
    assign seed_val   = (state == SEED);
    assign seed_msg   = cmd_q.seed;
    assign misr_clear = (state == SEED);
    assign misr_arm   = (state == RUN);
    // End of run: report, park the LFSR and drop vectors still in flight
    assign done       = (state == FINISH);
    assign flush      = (state == FINISH);
    assign lfsr_clear = (state == FINISH);

endmodule

`default_nettype wire

/* hw/lbist_cut_pkg.sv */
// CUT package with the test vector and response layouts and the ALU opcodes
`default_nettype none

`include "lbist_config.svh"

package lbist_cut_pkg;

    // Operand width is half a word
    localparam int HALF_BITS = `LBIST_WIDTH / 2;
    // Opcode takes the top two bits, b gets the rest of the upper half
    localparam int B_BITS = HALF_BITS - 2;

    // ALU operations of the circuit under test
    typedef enum logic [1:0] {
        ADD = 2'b00,
        SUB = 2'b01,
        XOR = 2'b10,
        AND = 2'b11
    } cut_op_e;

    // One LFSR word seen as CUT stimulus
    // Bits 31..30 op, 29..16 b, 15..0 a
    typedef struct packed {
        cut_op_e               op;
        logic [B_BITS-1:0]     b;
        logic [HALF_BITS-1:0]  a;
    } vector_t;

    // CUT output, operand a echoed above the ALU result
    typedef struct packed {
        logic [HALF_BITS-1:0]  a;
        logic [HALF_BITS-1:0]  result;
    } response_t;

endpackage

`default_nettype wire

/* hw/lbist_msg_pkg.sv */
// LBIST message package with the start command and run report formats
`default_nettype none

`include "lbist_config.svh"

package lbist_msg_pkg;

    // ======================================================================
    // Start command
    // ======================================================================

    // Sampled by the controller on the start pulse
    // A count of zero runs a single vector
    typedef struct packed {
        logic [`LBIST_WIDTH-1:0]    seed;
        logic [`LBIST_CNT_BITS-1:0] count;
    } start_cmd_t;

    // ======================================================================
    // Run report
    // ======================================================================

    // Final MISR value and the number of responses it absorbed
    typedef struct packed {
        logic [`LBIST_WIDTH-1:0]    signature;
        logic [`LBIST_CNT_BITS-1:0] count;
    } run_report_t;

endpackage

`default_nettype wire

/* hw/lbist_pipe_reg.sv */
// One-entry valid/ready pipeline register with a typed payload and a flush
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module lbist_pipe_reg #(
    parameter type payload_t = logic [`LBIST_WIDTH-1:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,

    // Upstream side
    input  logic     in_val,
    input  payload_t in_msg,
    output logic     in_rdy,

    // Downstream side
    output logic     out_val,
    output payload_t out_msg,
    input  logic     out_rdy
);

    logic     full;
    payload_t data;

    // Accept when empty or when the held entry leaves this cycle
    assign in_rdy = !full || out_rdy;

    // Occupancy, flush drops the entry and wins over a new load
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            full <= 1'b0;
        end else if (in_rdy) begin
            full <= in_val;
        end
    end

    // Payload loads only on an upstream transfer
    always_ff @(posedge clk) begin
        if (in_val && in_rdy) begin
            data <= in_msg;
        end
    end

    assign out_val = full;
    assign out_msg = data;

endmodule

`default_nettype wire

/* hw/lbist_top.sv */
// LBIST engine top level joining the LFSR, pipeline, CUT, MISR and controller
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module lbist_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  lbist_msg_pkg::start_cmd_t  cmd,
    input  logic                       pause,
    output logic                       busy,
    output logic                       done,
    output lbist_msg_pkg::run_report_t report
);

    import lbist_cut_pkg::*;

    // ======================================================================
    // Interconnect
    // ======================================================================

    // Controller to LFSR
    logic                    seed_val;
    logic                    seed_rdy;
    logic [`LBIST_WIDTH-1:0] seed_msg;
    logic                    lfsr_clear;

    // LFSR to pipe register 0
    logic                    vec_val;
    logic                    vec_rdy;
    vector_t                 vec_msg;

    // Pipe register 0 to CUT
    logic                    cut_in_val;
    logic                    cut_in_rdy;
    vector_t                 cut_in_msg;

    // CUT to pipe register 1
    logic                    cut_out_val;
    logic                    cut_out_rdy;
    response_t               cut_out_msg;

    // Pipe register 1 to MISR
    logic                    rsp_val;
    logic                    rsp_rdy;
    response_t               rsp_msg;

    // MISR and pipeline control
    logic                    misr_clear;
    logic                    misr_arm;
    logic                    absorbed;
    logic [`LBIST_WIDTH-1:0] signature;
    logic                    flush;

    // ======================================================================
    // Stream path
    // ======================================================================

    lfsr lfsr_i (
        .clk      (clk),
        .reset    (reset),
        .clear    (lfsr_clear),
        .seed_msg (seed_msg),
        .seed_val (seed_val),
        .seed_rdy (seed_rdy),
        .vec_rdy  (vec_rdy),
        .vec_val  (vec_val),
        .vec_msg  (vec_msg)
    );

    lbist_pipe_reg #(.payload_t(vector_t)) vec_reg_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .in_val  (vec_val),
        .in_msg  (vec_msg),
        .in_rdy  (vec_rdy),
        .out_val (cut_in_val),
        .out_msg (cut_in_msg),
        .out_rdy (cut_in_rdy)
    );

    cut_datapath cut_i (
        .in_val  (cut_in_val),
        .in_msg  (cut_in_msg),
        .in_rdy  (cut_in_rdy),
        .out_val (cut_out_val),
        .out_msg (cut_out_msg),
        .out_rdy (cut_out_rdy)
    );

    lbist_pipe_reg #(.payload_t(response_t)) rsp_reg_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .in_val  (cut_out_val),
        .in_msg  (cut_out_msg),
        .in_rdy  (cut_out_rdy),
        .out_val (rsp_val),
        .out_msg (rsp_msg),
        .out_rdy (rsp_rdy)
    );

    misr misr_i (
        .clk       (clk),
        .reset     (reset),
        .clear     (misr_clear),
        .arm       (misr_arm),
        .pause     (pause),
        .rsp_val   (rsp_val),
        .rsp_msg   (rsp_msg),
        .rsp_rdy   (rsp_rdy),
        .absorbed  (absorbed),
        .signature (signature)
    );

    // ======================================================================
    // Run control
    // ======================================================================

    lbist_controller ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cmd        (cmd),
        .seed_val   (seed_val),
        .seed_msg   (seed_msg),
        .seed_rdy   (seed_rdy),
        .lfsr_clear (lfsr_clear),
        .misr_clear (misr_clear),
        .misr_arm   (misr_arm),
        .absorbed   (absorbed),
        .signature  (signature),
        .flush      (flush),
        .busy       (busy),
        .done       (done),
        .report     (report)
    );

endmodule

`default_nettype wire

/* hw/lfsr.sv */
// LFSR vector source with a valid/ready seed channel and a vector stream output
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module lfsr (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,

    // Seed request from the controller
    input  logic [`LBIST_WIDTH-1:0] seed_msg,
    input  logic                    seed_val,
    output logic                    seed_rdy,

    // Vector stream towards the CUT pipeline
    input  logic                    vec_rdy,
    output logic                    vec_val,
    output lbist_cut_pkg::vector_t  vec_msg
);

    import lbist_cut_pkg::*;

    // ======================================================================
    // State and shift register
    // ======================================================================

    // IDLE tracks the seed, GEN streams vectors
    typedef enum logic {
        IDLE,
        GEN
    } lfsr_state_e;

    lfsr_state_e             state;
    lfsr_state_e             next_state;

    logic [`LBIST_WIDTH-1:0] q;
    logic [`LBIST_WIDTH-1:0] next_q;
    logic                    feedback;

    // Fibonacci feedback, XOR of the four taps enters at bit 0
    assign feedback = q[`LBIST_TAP1] ^ q[`LBIST_TAP2] ^ q[`LBIST_TAP3] ^ q[`LBIST_TAP4];
    assign next_q   = {q[`LBIST_WIDTH-2:0], feedback};

    // ======================================================================
    // Next state
    // ======================================================================

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Seed accepted on the request transfer
                if (seed_val) begin
                    next_state = GEN;
                end
            end
            GEN: begin
                if (clear) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Shift register holds the seed in idle
    // Advances only on an accepted vector
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (seed_val) begin
                q <= seed_msg;
            end
        end else if (vec_val && vec_rdy) begin
            q <= next_q;
        end
    end

    // ======================================================================
    // Channel outputs
    // ======================================================================

    // Ready for a seed only while idle
    assign seed_rdy = (state == IDLE);
    // First vector out is the seed itself
    assign vec_val  = (state == GEN);
    assign vec_msg  = vector_t'(q);

endmodule

`default_nettype wire

/* hw/misr.sv */
// MISR signature compactor for CUT responses with clear, arm and pause control
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module misr (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear,
    input  logic                     arm,
    input  logic                     pause,

    // Response stream from the last pipe register
    input  logic                     rsp_val,
    input  lbist_cut_pkg::response_t rsp_msg,
    output logic                     rsp_rdy,

    // Status back to the controller
    output logic                     absorbed,
    output logic [`LBIST_WIDTH-1:0]  signature
);

    logic [`LBIST_WIDTH-1:0] sig;
    logic [`LBIST_WIDTH-1:0] next_sig;
    logic                    feedback;

    // Pause withholds ready, stalling the whole pipeline behind it
    assign rsp_rdy  = arm && !pause;
    assign absorbed = rsp_val && rsp_rdy;

    // Same polynomial as the LFSR, then fold in the response word
    assign feedback = sig[`LBIST_TAP1] ^ sig[`LBIST_TAP2] ^
                      sig[`LBIST_TAP3] ^ sig[`LBIST_TAP4];
    assign next_sig = {sig[`LBIST_WIDTH-2:0], feedback} ^ rsp_msg;

    // ======================================================================
    // Signature register
    // ======================================================================

    // Clear has priority over an absorb
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sig <= '0;
        end else if (absorbed) begin
            sig <= next_sig;
        end
    end

    assign signature = sig;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the LBIST testbench with Verilator and run it once.
# The run passes only if the testbench prints its pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module lbist_tb \
    --Mdir obj_dir \
    -o lbist_sim \
    -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/lbist_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Test completed successfully$'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb/lbist_tb.sv */
// Testbench for the LBIST engine that checks run reports against a reference model
`default_nettype none
`timescale 1ns/10ps

`include "lbist_config.svh"

module lbist_tb;

    import lbist_msg_pkg::*;
    import lbist_cut_pkg::*;

    localparam int NUM_RANDOM = 20;

    // ======================================================================
    // DUT signals and bookkeeping
    // ======================================================================

    logic                       clk;
    logic                       reset;
    logic                       start;
    start_cmd_t                 cmd;
    logic                       pause;
    logic                       busy;
    logic                       done;
    run_report_t                report;

    // Random stream state
    integer                     seed;

    // Expected reports in run order, pushed at each start
    run_report_t                expected_q[$];
    run_report_t                expected;
    run_report_t                last_report;
    logic                       have_last;
    logic                       done_prev;
    int                         done_count;
    int                         runs_started;

    // Random runs, replayed later with pause
    logic [`LBIST_WIDTH-1:0]    rand_seeds[NUM_RANDOM];
    logic [`LBIST_CNT_BITS-1:0] rand_counts[NUM_RANDOM];

    lbist_top dut_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .cmd    (cmd),
        .pause  (pause),
        .busy   (busy),
        .done   (done),
        .report (report)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // ======================================================================
    // Reference model
    // ======================================================================

    // Shift left, XOR of taps 1, 5, 6 and 31 enters at bit 0
    // Same step for the LFSR and the MISR
    function automatic logic [`LBIST_WIDTH-1:0] shift_feedback(
        input logic [`LBIST_WIDTH-1:0] q
    );
        logic fb;
        fb = q[`LBIST_TAP1] ^ q[`LBIST_TAP2] ^ q[`LBIST_TAP3] ^ q[`LBIST_TAP4];
        return {q[`LBIST_WIDTH-2:0], fb};
    endfunction

    // ALU response for one vector, a above the 16-bit result
    function automatic logic [31:0] alu_response(input logic [31:0] v);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        a = v[15:0];
        b = {2'b00, v[29:16]};
        case (v[31:30])
            2'b00:   res = a + b;
            2'b01:   res = a - b;
            2'b10:   res = a ^ b;
            default: res = a & b;
        endcase
        return {a, res};
    endfunction

    // Vector 0 is the seed, MISR starts from zero
    function automatic logic [`LBIST_WIDTH-1:0] expected_signature(
        input logic [`LBIST_WIDTH-1:0]    run_seed,
        input logic [`LBIST_CNT_BITS-1:0] run_count
    );
        logic [`LBIST_WIDTH-1:0] q;
        logic [`LBIST_WIDTH-1:0] sig;
        int                      n;
        int                      i;
        n   = (run_count == '0) ? 1 : int'(run_count);
        q   = run_seed;
        sig = '0;
        for (i = 0; i < n; i++) begin
            sig = shift_feedback(sig) ^ alu_response(q);
            q   = shift_feedback(q);
        end
        return sig;
    endfunction

    function automatic run_report_t expected_report(
        input logic [`LBIST_WIDTH-1:0]    run_seed,
        input logic [`LBIST_CNT_BITS-1:0] run_count
    );
        run_report_t r;
        r.signature = expected_signature(run_seed, run_count);
        // Zero count reports as one
        r.count     = (run_count == '0) ? {{(`LBIST_CNT_BITS-1){1'b0}}, 1'b1} : run_count;
        return r;
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_report(input string what, input run_report_t got,
                                input run_report_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s got sig %h count %0d, expected sig %h count %0d",
                                $time, what, got.signature, got.count,
                                exp.signature, exp.count));
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Compare process, sampled at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!reset) begin
            if (done) begin
                check_level("done in the cycle before a done", done_prev, 1'b0);
                if (expected_q.size() == 0) begin
                    abort_run("done pulsed while no run was pending");
                end else begin
                    expected = expected_q.pop_front();
                    check_report("run report", report, expected);
                    last_report = expected;
                    have_last   = 1'b1;
                    done_count++;
                end
            end else if (have_last) begin
                // Report holds between done pulses
                check_report("held report", report, last_report);
            end
            done_prev = done;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= 100) begin
                abort_run("timeout: busy stayed high before a new start");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    // One run from start to done, optional random pause and a stray start
    task automatic run_test(input logic [`LBIST_WIDTH-1:0] run_seed,
                            input logic [`LBIST_CNT_BITS-1:0] run_count,
                            input logic random_pause, input logic extra_start);
        int          cycles;
        int          limit;
        int          done_before;
        logic [31:0] r;
        wait_idle();
        expected_q.push_back(expected_report(run_seed, run_count));
        runs_started++;
        done_before = done_count;
        limit       = 6 * int'(run_count) + 50;
        start       = 1'b1;
        cmd.seed    = run_seed;
        cmd.count   = run_count;
        next_cycle();
        start = 1'b0;
        check_level("busy after start", busy, 1'b1);
        cycles = 0;
        while (done_count == done_before) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout: no done within %0d cycles of start", limit));
            end else begin
                r     = $random(seed);
                pause = random_pause & r[0];
                // Start while busy must be ignored
                start = extra_start && (cycles == 3);
                if (start) begin
                    check_level("busy at stray start", busy, 1'b1);
                    cmd.seed  = ~run_seed;
                    cmd.count = 16'd3;
                end
                next_cycle();
                cycles++;
            end
        end
        pause = 1'b0;
        start = 1'b0;
    endtask

    // A few idle cycles with no further done pulse
    task automatic check_quiet();
        repeat (6) next_cycle();
        check_level("busy after run", busy, 1'b0);
        if (done_count != runs_started) begin
            abort_run("done pulsed a different number of times than runs were started");
        end
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        run_report_t fixed;
        run_report_t single;
        seed         = 14976;
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        cmd          = '0;
        pause        = 1'b0;
        have_last    = 1'b0;
        done_prev    = 1'b0;
        done_count   = 0;
        runs_started = 0;
        repeat (2) next_cycle();
        reset = 1'b0;

        // Quiet after reset
        for (i = 0; i < 5; i++) begin
            check_level("busy after reset", busy, 1'b0);
            check_level("done after reset", done, 1'b0);
            next_cycle();
        end

        // Fixed seed, eight vectors
        run_test(32'h1234_5678, 16'd8, 1'b0, 1'b0);
        fixed.signature = expected_signature(32'h1234_5678, 16'd8);
        fixed.count     = 16'd8;
        check_report("fixed seed report", report, fixed);

        // Random seeds and counts without pause
        for (i = 0; i < NUM_RANDOM; i++) begin
            r              = $random(seed);
            rand_seeds[i]  = r;
            r              = $random(seed);
            rand_counts[i] = 16'(32'd1 + (r % 32'd200));
            run_test(rand_seeds[i], rand_counts[i], 1'b0, 1'b0);
        end

        // Same runs under back-pressure
        for (i = 0; i < NUM_RANDOM; i++) begin
            run_test(rand_seeds[i], rand_counts[i], 1'b1, 1'b0);
        end

        // Back-to-back reseeds, one with a stray start mid-run
        run_test(32'hdead_beef, 16'd40, 1'b0, 1'b0);
        run_test(32'h0bad_f00d, 16'd25, 1'b1, 1'b1);
        run_test(32'h8000_0001, 16'd12, 1'b0, 1'b1);
        run_test(32'h5a5a_a5a5, 16'd9, 1'b1, 1'b0);
        check_quiet();

        // Count 1 and count 0 give the same single-vector result
        single = expected_report(32'hc001_cafe, 16'd1);
        run_test(32'hc001_cafe, 16'd1, 1'b0, 1'b0);
        check_quiet();
        check_report("count 1 report", report, single);
        run_test(32'hc001_cafe, 16'd0, 1'b0, 1'b0);
        check_quiet();
        check_report("count 0 against count 1", report, single);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
